/* Makefile */
VERILATOR ?= verilator
CC        ?= g++
TOP       ?= ex_stage_tb
SEED      ?= 36072
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
PASS_MSG  := all tests passed

VFLAGS = --binary --timing --assert -Wno-fatal --top-module $(TOP) -GSEED=$(SEED) \
         --Mdir $(OBJ_DIR) -MAKEFLAGS "CXX=$(CC)"

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* hw/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  ex_pkg::branch_req_t req,
    output ex_pkg::unit_done_t  done
);

    logic cond_holds;

    // compare on raw register values, not the target operands
    always_comb begin
        case (req.funct3)
            3'b000:  cond_holds = (req.rs1_value == req.rs2_value);
            3'b001:  cond_holds = (req.rs1_value != req.rs2_value);
            3'b100:  cond_holds = ($signed(req.rs1_value) < $signed(req.rs2_value));
            3'b101:  cond_holds = ($signed(req.rs1_value) >= $signed(req.rs2_value));
            3'b110:  cond_holds = (req.rs1_value < req.rs2_value);
            3'b111:  cond_holds = (req.rs1_value >= req.rs2_value);
            default: cond_holds = 1'b0;
        endcase
    end

    always_comb begin
        done.done        = req.valid;
        // target address
        done.result      = req.opa + req.opb;
        done.take_branch = req.uncond_branch || (req.cond_branch && cond_holds);
        done.tag         = req.tag;
    end

endmodule

/* hw/completion_arbiter.sv */
`timescale 1ns/1ps
`include "ex_consts.svh"

module completion_arbiter (
    input  logic               clock,
    input  logic               reset,
    input  ex_pkg::unit_done_t alu_done,
    input  ex_pkg::unit_done_t branch_done,
    input  ex_pkg::mult_item_t mult_done,
    output ex_pkg::ex_result_t result,
    output logic               free_alu,
    output logic               free_mult,
    output logic               free_branch
);

    localparam int DEPTH = `MULT_STAGES;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // single holding slots
    logic               alu_full;
    logic               br_full;
    ex_pkg::unit_done_t alu_slot;
    ex_pkg::unit_done_t br_slot;

    // multiplier FIFO
    ex_pkg::word_t      mq_result [DEPTH];
    ex_pkg::ex_tag_t    mq_tag [DEPTH];
    logic [PTR_W-1:0]   mq_head;
    logic [PTR_W-1:0]   mq_tail;
    logic [CNT_W-1:0]   mq_count;
    logic               mq_push;
    logic               mq_pop;
    ex_pkg::word_t      mult_word;

    logic               grant_alu;
    logic               grant_mult;
    logic               grant_br;
    ex_pkg::ex_result_t pick;
    ex_pkg::ex_result_t out_q;
    logic               out_valid;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign mult_word = mult_done.upper ? mult_done.product[2*`XLEN-1:`XLEN]
                                       : mult_done.product[`XLEN-1:0];
    assign mq_push   = mult_done.valid;

    // fixed priority, ALU then multiplier head then branch
    assign grant_alu  = alu_full;
    assign grant_mult = !alu_full && (mq_count != '0);
    assign grant_br   = !alu_full && (mq_count == '0) && br_full;
    assign mq_pop     = grant_mult;

    always_comb begin
        pick       = '0;
        pick.valid = grant_alu || grant_mult || grant_br;
        if (grant_alu) begin
            pick.unit        = ex_pkg::FU_ALU;
            pick.result      = alu_slot.result;
            pick.take_branch = alu_slot.take_branch;
            pick.tag         = alu_slot.tag;
        end else if (grant_mult) begin
            pick.unit   = ex_pkg::FU_MULT;
            pick.result = mq_result[mq_head];
            pick.tag    = mq_tag[mq_head];
        end else if (grant_br) begin
            pick.unit        = ex_pkg::FU_BRANCH;
            pick.result      = br_slot.result;
            pick.take_branch = br_slot.take_branch;
            pick.tag         = br_slot.tag;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // occupancy and output strobes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_full    <= 1'b0;
            br_full     <= 1'b0;
            mq_head     <= '0;
            mq_tail     <= '0;
            mq_count    <= '0;
            out_valid   <= 1'b0;
            free_alu    <= 1'b0;
            free_mult   <= 1'b0;
            free_branch <= 1'b0;
        end else begin
            if (alu_done.done) begin
                alu_full <= 1'b1;
            end else if (grant_alu) begin
                alu_full <= 1'b0;
            end
            if (branch_done.done) begin
                br_full <= 1'b1;
            end else if (grant_br) begin
                br_full <= 1'b0;
            end
            if (mq_push) begin
                mq_tail <= ptr_next(mq_tail);
            end
            if (mq_pop) begin
                mq_head <= ptr_next(mq_head);
            end
            mq_count    <= mq_count + CNT_W'(mq_push) - CNT_W'(mq_pop);
            out_valid   <= pick.valid;
            free_alu    <= grant_alu;
            free_mult   <= grant_mult;
            free_branch <= grant_br;
        end
    end

    // payload
    always_ff @(posedge clock) begin
        if (alu_done.done) begin
            alu_slot <= alu_done;
        end
        if (branch_done.done) begin
            br_slot <= branch_done;
        end
        if (mq_push) begin
            mq_result[mq_tail] <= mult_word;
            mq_tag[mq_tail]    <= mult_done.tag;
        end
        if (pick.valid) begin
            out_q <= pick;
        end
    end

    always_comb begin
        result       = out_q;
        result.valid = out_valid;
    end

    // the issuer only refills a unit after its free pulse
    a_alu_slot: assert property (@(posedge clock) disable iff (reset)
        alu_done.done |-> !alu_full)
        else $error("ALU done while its slot is still full");

    a_branch_slot: assert property (@(posedge clock) disable iff (reset)
        branch_done.done |-> !br_full)
        else $error("branch done while its slot is still full");

    a_mq_room: assert property (@(posedge clock) disable iff (reset)
        mq_push |-> (mq_count != CNT_W'(DEPTH)))
        else $error("multiply pushed into a full queue");

endmodule

/* hw/ex_pkg.sv */
`include "ex_consts.svh"

package ex_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [2*`XLEN-1:0]    dword_t;
    typedef logic [31:0]           inst_t;
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0]            funct3_t;

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MULT   = 2'd1,
        FU_BRANCH = 2'd2
    } fu_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHSU,
        ALU_MULHU
    } alu_func_e;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_NPC,
        OPA_PC,
        OPA_ZERO
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_RS2,
        OPB_I_IMM,
        OPB_S_IMM,
        OPB_B_IMM,
        OPB_U_IMM,
        OPB_J_IMM
    } opb_sel_e;

    ////////////////////////////////////////////////////////////////////////////
    // packets
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        rob_idx_t rob_index;
        reg_idx_t dest_reg;
    } ex_tag_t;

    // one issued instruction
    typedef struct packed {
        logic      valid;
        fu_type_e  unit;
        alu_func_e alu_func;
        opa_sel_e  opa_select;
        opb_sel_e  opb_select;
        inst_t     inst;
        word_t     pc;
        word_t     npc;
        word_t     rs1_value;
        word_t     rs2_value;
        rob_idx_t  rob_index;
        reg_idx_t  dest_reg;
        logic      cond_branch;
        logic      uncond_branch;
    } ex_issue_t;

    typedef struct packed {
        logic      valid;
        alu_func_e func;
        word_t     opa;
        word_t     opb;
        ex_tag_t   tag;
    } alu_req_t;

    // target operands plus raw register values for the compare
    typedef struct packed {
        logic    valid;
        word_t   opa;
        word_t   opb;
        word_t   rs1_value;
        word_t   rs2_value;
        funct3_t funct3;
        logic    cond_branch;
        logic    uncond_branch;
        ex_tag_t tag;
    } branch_req_t;

    // one multiply travelling down the stage chain
    typedef struct packed {
        logic    valid;
        dword_t  mcand;
        dword_t  mplier;
        dword_t  product;
        logic    upper;
        ex_tag_t tag;
    } mult_item_t;

    typedef struct packed {
        logic    done;
        word_t   result;
        logic    take_branch;
        ex_tag_t tag;
    } unit_done_t;

    typedef struct packed {
        logic     valid;
        fu_type_e unit;
        word_t    result;
        logic     take_branch;
        ex_tag_t  tag;
    } ex_result_t;

endpackage

/* hw/ex_stage.sv */
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage (
    input  logic              clock,
    input  logic              reset,
    input  ex_pkg::ex_issue_t issue,
    output ex_pkg::ex_result_t result,
    output logic              free_alu,
    output logic              free_mult,
    output logic              free_branch
);

    ex_pkg::alu_req_t    alu_in;
    ex_pkg::branch_req_t branch_in;
    ex_pkg::unit_done_t  alu_done;
    ex_pkg::unit_done_t  branch_done;

    // entry 0 comes from operand select, the last entry feeds the arbiter
    ex_pkg::mult_item_t  mult_chain [`MULT_STAGES+1];

    operand_select u_operand_select (
        .issue     (issue),
        .alu_in    (alu_in),
        .branch_in (branch_in),
        .mult_in   (mult_chain[0])
    );

    int_alu u_int_alu (
        .req  (alu_in),
        .done (alu_done)
    );

    branch_unit u_branch_unit (
        .req  (branch_in),
        .done (branch_done)
    );

    for (genvar i = 0; i < `MULT_STAGES; i++) begin : g_mult
        mult_stage u_mult_stage (
            .clock     (clock),
            .reset     (reset),
            .stage_in  (mult_chain[i]),
            .stage_out (mult_chain[i+1])
        );
    end

    completion_arbiter u_completion_arbiter (
        .clock       (clock),
        .reset       (reset),
        .alu_done    (alu_done),
        .branch_done (branch_done),
        .mult_done   (mult_chain[`MULT_STAGES]),
        .result      (result),
        .free_alu    (free_alu),
        .free_mult   (free_mult),
        .free_branch (free_branch)
    );

endmodule

/* hw/int_alu.sv */
`timescale 1ns/1ps

module int_alu (
    input  ex_pkg::alu_req_t   req,
    output ex_pkg::unit_done_t done
);

    localparam int SHAMT_W = $clog2($bits(ex_pkg::word_t));

    ex_pkg::word_t        result;
    logic [SHAMT_W-1:0]   shamt;

    assign shamt = req.opb[SHAMT_W-1:0];

    always_comb begin
        case (req.func)
            ex_pkg::ALU_ADD:  result = req.opa + req.opb;
            ex_pkg::ALU_SUB:  result = req.opa - req.opb;
            ex_pkg::ALU_SLT:  result = ex_pkg::word_t'($signed(req.opa) < $signed(req.opb));
            ex_pkg::ALU_SLTU: result = ex_pkg::word_t'(req.opa < req.opb);
            ex_pkg::ALU_AND:  result = req.opa & req.opb;
            ex_pkg::ALU_OR:   result = req.opa | req.opb;
            ex_pkg::ALU_XOR:  result = req.opa ^ req.opb;
            ex_pkg::ALU_SLL:  result = req.opa << shamt;
            ex_pkg::ALU_SRL:  result = req.opa >> shamt;
            ex_pkg::ALU_SRA:  result = ex_pkg::word_t'($signed(req.opa) >>> shamt);
            // multiplies never reach this unit
            default:          result = '0;
        endcase
    end

    always_comb begin
        done.done        = req.valid;
        done.result      = result;
        done.take_branch = 1'b0;
        done.tag         = req.tag;
    end

endmodule

/* hw/mult_stage.sv */
`timescale 1ns/1ps
`include "ex_consts.svh"

module mult_stage (
    input  logic               clock,
    input  logic               reset,
    input  ex_pkg::mult_item_t stage_in,
    output ex_pkg::mult_item_t stage_out
);

    ex_pkg::dword_t     partial;
    ex_pkg::mult_item_t next_item;
    ex_pkg::mult_item_t item_q;
    logic               valid_q;

    // partial product for the low slice of the multiplier
    assign partial = stage_in.mcand * stage_in.mplier[`MULT_SLICE-1:0];

    always_comb begin
        next_item         = stage_in;
        next_item.product = stage_in.product + partial;
        next_item.mcand   = stage_in.mcand << `MULT_SLICE;
        next_item.mplier  = stage_in.mplier >> `MULT_SLICE;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_in.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (stage_in.valid) begin
            item_q <= next_item;
        end
    end

    always_comb begin
        stage_out       = item_q;
        stage_out.valid = valid_q;
    end

endmodule

/* hw/operand_select.sv */
`timescale 1ns/1ps
`include "ex_consts.svh"

module operand_select (
    input  ex_pkg::ex_issue_t   issue,
    output ex_pkg::alu_req_t    alu_in,
    output ex_pkg::branch_req_t branch_in,
    output ex_pkg::mult_item_t  mult_in
);

    ex_pkg::inst_t   inst;
    ex_pkg::word_t   opa;
    ex_pkg::word_t   opb;
    ex_pkg::ex_tag_t tag;
    logic            sign_a;
    logic            sign_b;

    assign inst = issue.inst;
    assign tag  = '{rob_index: issue.rob_index, dest_reg: issue.dest_reg};

    // operand A
    always_comb begin
        case (issue.opa_select)
            ex_pkg::OPA_RS1:  opa = issue.rs1_value;
            ex_pkg::OPA_NPC:  opa = issue.npc;
            ex_pkg::OPA_PC:   opa = issue.pc;
            ex_pkg::OPA_ZERO: opa = '0;
            default:          opa = '0;
        endcase
    end

    // operand B, every immediate sign extended from inst[31]
    always_comb begin
        case (issue.opb_select)
            ex_pkg::OPB_RS2:   opb = issue.rs2_value;
            ex_pkg::OPB_I_IMM: opb = ex_pkg::word_t'($signed(inst[31:20]));
            ex_pkg::OPB_S_IMM: opb = ex_pkg::word_t'($signed({inst[31:25], inst[11:7]}));
            ex_pkg::OPB_B_IMM: opb = ex_pkg::word_t'($signed({inst[31], inst[7],
                                         inst[30:25], inst[11:8], 1'b0}));
            ex_pkg::OPB_U_IMM: opb = ex_pkg::word_t'($signed({inst[31:12], 12'h000}));
            ex_pkg::OPB_J_IMM: opb = ex_pkg::word_t'($signed({inst[31], inst[19:12],
                                         inst[20], inst[30:21], 1'b0}));
            default:           opb = '0;
        endcase
    end

    // MULHSU treats only the multiplicand as signed
    assign sign_a = issue.alu_func inside {ex_pkg::ALU_MUL, ex_pkg::ALU_MULH, ex_pkg::ALU_MULHSU};
    assign sign_b = issue.alu_func inside {ex_pkg::ALU_MUL, ex_pkg::ALU_MULH};

    always_comb begin
        alu_in.valid = issue.valid && (issue.unit == ex_pkg::FU_ALU);
        alu_in.func  = issue.alu_func;
        alu_in.opa   = opa;
        alu_in.opb   = opb;
        alu_in.tag   = tag;

        branch_in.valid         = issue.valid && (issue.unit == ex_pkg::FU_BRANCH);
        branch_in.opa           = opa;
        branch_in.opb           = opb;
        branch_in.rs1_value     = issue.rs1_value;
        branch_in.rs2_value     = issue.rs2_value;
        branch_in.funct3        = inst[14:12];
        branch_in.cond_branch   = issue.cond_branch;
        branch_in.uncond_branch = issue.uncond_branch;
        branch_in.tag           = tag;

        // widen to double width so the stage chain sees two's complement values
        mult_in.valid   = issue.valid && (issue.unit == ex_pkg::FU_MULT);
        mult_in.mcand   = sign_a ? {{`XLEN{opa[`XLEN-1]}}, opa} : {{`XLEN{1'b0}}, opa};
        mult_in.mplier  = sign_b ? {{`XLEN{opb[`XLEN-1]}}, opb} : {{`XLEN{1'b0}}, opb};
        mult_in.product = '0;
        mult_in.upper   = issue.alu_func inside {ex_pkg::ALU_MULH, ex_pkg::ALU_MULHSU,
                                                 ex_pkg::ALU_MULHU};
        mult_in.tag     = tag;
    end

    a_unit_defined: assert final (!issue.valid ||
        issue.unit inside {ex_pkg::FU_ALU, ex_pkg::FU_MULT, ex_pkg::FU_BRANCH})
        else $error("valid issue with undefined unit %0d", issue.unit);

endmodule

/* include/ex_consts.svh */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

// one data word
`define XLEN 32

// reorder buffer tag
`define ROB_IDX_W 5

// architectural register index
`define REG_IDX_W 5

////////////////////////////////////////////////////////////////////////////
// multiplier shape
////////////////////////////////////////////////////////////////////////////

// pipeline depth, one of 1, 2, 4 or 8
`define MULT_STAGES 4

// multiplier bits retired by each stage
`define MULT_SLICE ((2 * `XLEN) / `MULT_STAGES)

`endif

/* src.f */
+incdir+include
hw/ex_pkg.sv
hw/operand_select.sv
hw/int_alu.sv
hw/branch_unit.sv
hw/mult_stage.sv
hw/completion_arbiter.sv
hw/ex_stage.sv
test/ex_stage_tb.sv

/* test/ex_stage_tb.sv */
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage_tb #(
    parameter logic [31:0] SEED = 32'h8ce8
);

    localparam int N_OPS        = 400;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_LIMIT  = 8 * `MULT_STAGES + 32;
    localparam int WATCHDOG_NS  = N_OPS * (`MULT_STAGES + 8) * CLK_PERIOD;

    logic               clock;
    logic               reset;
    ex_pkg::ex_issue_t  issue;
    ex_pkg::ex_result_t result;
    logic               free_alu;
    logic               free_mult;
    logic               free_branch;

    logic [31:0]        rng;
    int                 ops_sent;
    logic               seen_issue;
    int                 issued_alu;
    int                 issued_mult;
    int                 issued_br;
    int                 freed_alu;
    int                 freed_mult;
    int                 freed_br;
    int                 value_errors;
    int                 protocol_errors;
    int                 leftover_errors;

    // expected completions per unit, in issue order
    ex_pkg::unit_done_t exp_alu[$];
    ex_pkg::unit_done_t exp_mult[$];
    ex_pkg::unit_done_t exp_br[$];

    ex_stage u_dut (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .result      (result),
        .free_alu    (free_alu),
        .free_mult   (free_mult),
        .free_branch (free_branch)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic ex_pkg::word_t model_opa(input ex_pkg::ex_issue_t op);
        case (op.opa_select)
            ex_pkg::OPA_RS1: return op.rs1_value;
            ex_pkg::OPA_NPC: return op.npc;
            ex_pkg::OPA_PC:  return op.pc;
            default:         return 32'h0;
        endcase
    endfunction

    // immediate layouts from the base ISA encoding
    function automatic ex_pkg::word_t model_opb(input ex_pkg::ex_issue_t op);
        ex_pkg::inst_t i;
        i = op.inst;
        case (op.opb_select)
            ex_pkg::OPB_I_IMM: return {{20{i[31]}}, i[31:20]};
            ex_pkg::OPB_S_IMM: return {{20{i[31]}}, i[31:25], i[11:7]};
            ex_pkg::OPB_B_IMM: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            ex_pkg::OPB_U_IMM: return {i[31:12], 12'h000};
            ex_pkg::OPB_J_IMM: return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            default:           return op.rs2_value;
        endcase
    endfunction

    function automatic ex_pkg::word_t model_alu(input ex_pkg::alu_func_e f,
                                                input ex_pkg::word_t a, input ex_pkg::word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f)
            ex_pkg::ALU_ADD:  return a + b;
            ex_pkg::ALU_SUB:  return a + ~b + 32'h1;
            // signed order is unsigned order with the sign bits flipped
            ex_pkg::ALU_SLT:  return {31'h0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            ex_pkg::ALU_SLTU: return {31'h0, a < b};
            ex_pkg::ALU_AND:  return a & b;
            ex_pkg::ALU_OR:   return a | b;
            ex_pkg::ALU_XOR:  return a ^ b;
            ex_pkg::ALU_SLL:  return a << sh;
            ex_pkg::ALU_SRL:  return a >> sh;
            ex_pkg::ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            default:          return 32'h0;
        endcase
    endfunction

    function automatic ex_pkg::word_t model_mult(input ex_pkg::alu_func_e f,
                                                 input ex_pkg::word_t a, input ex_pkg::word_t b);
        logic        sa;
        logic        sb;
        logic [63:0] p;
        sa = f inside {ex_pkg::ALU_MUL, ex_pkg::ALU_MULH, ex_pkg::ALU_MULHSU};
        sb = f inside {ex_pkg::ALU_MUL, ex_pkg::ALU_MULH};
        p  = {{32{sa & a[31]}}, a} * {{32{sb & b[31]}}, b};
        return (f == ex_pkg::ALU_MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic model_taken(input ex_pkg::ex_issue_t op);
        ex_pkg::word_t r1;
        ex_pkg::word_t r2;
        logic          holds;
        r1 = op.rs1_value;
        r2 = op.rs2_value;
        case (op.inst[14:12])
            3'b000:  holds = r1 == r2;
            3'b001:  holds = r1 != r2;
            3'b100:  holds = (r1 ^ 32'h8000_0000) < (r2 ^ 32'h8000_0000);
            3'b101:  holds = !((r1 ^ 32'h8000_0000) < (r2 ^ 32'h8000_0000));
            3'b110:  holds = r1 < r2;
            3'b111:  holds = !(r1 < r2);
            default: holds = 1'b0;
        endcase
        return op.uncond_branch || (op.cond_branch && holds);
    endfunction

    function automatic logic has_credit(input ex_pkg::fu_type_e unit);
        case (unit)
            ex_pkg::FU_ALU:  return (issued_alu - freed_alu) < 1;
            ex_pkg::FU_MULT: return (issued_mult - freed_mult) < `MULT_STAGES;
            default:         return (issued_br - freed_br) < 1;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input string what, input ex_pkg::word_t got,
                              input ex_pkg::word_t want);
        if (got !== want) begin
            value_errors++;
            $display("FAIL %0t: %s result %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic want);
        if (got !== want) begin
            value_errors++;
            $display("FAIL %0t: %s take_branch %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_tag(input string what, input ex_pkg::ex_tag_t got,
                             input ex_pkg::ex_tag_t want);
        if (got !== want) begin
            value_errors++;
            $display("FAIL %0t: %s tag rob %0d rd %0d, expected rob %0d rd %0d", $time, what,
                     got.rob_index, got.dest_reg, want.rob_index, want.dest_reg);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic issue_op(input ex_pkg::fu_type_e unit);
        ex_pkg::ex_issue_t  op;
        ex_pkg::unit_done_t want;
        logic [31:0]        r;
        r                = next_random();
        op               = '0;
        op.valid         = 1'b1;
        op.unit          = unit;
        op.opa_select    = ex_pkg::opa_sel_e'(r[1:0]);
        op.opb_select    = ex_pkg::opb_sel_e'(r[4:2] % 3'd6);
        op.inst          = next_random();
        op.pc            = next_random();
        op.npc           = op.pc + 32'h4;
        op.rs1_value     = next_random();
        op.rs2_value     = (r[7:6] == 2'b00) ? op.rs1_value : next_random();
        op.rob_index     = r[20:16];
        op.dest_reg      = r[25:21];
        op.cond_branch   = (r[27:26] == 2'b01) || (r[27:26] == 2'b10);
        op.uncond_branch = (r[27:26] == 2'b11);
        if (unit == ex_pkg::FU_MULT) begin
            op.alu_func = ex_pkg::alu_func_e'(4'd10 + {2'b00, r[13:12]});
        end else begin
            op.alu_func = ex_pkg::alu_func_e'(r[11:8] % 4'd10);
        end
        want      = '0;
        want.done = 1'b1;
        want.tag  = '{rob_index: op.rob_index, dest_reg: op.dest_reg};
        case (unit)
            ex_pkg::FU_ALU: begin
                want.result = model_alu(op.alu_func, model_opa(op), model_opb(op));
                exp_alu.push_back(want);
                issued_alu++;
            end
            ex_pkg::FU_MULT: begin
                want.result = model_mult(op.alu_func, model_opa(op), model_opb(op));
                exp_mult.push_back(want);
                issued_mult++;
            end
            default: begin
                want.result      = model_opa(op) + model_opb(op);
                want.take_branch = model_taken(op);
                exp_br.push_back(want);
                issued_br++;
            end
        endcase
        issue      <= op;
        seen_issue = 1'b1;
        ops_sent++;
    endtask

    // multiplies get half the picks so that bursts fill the pipeline
    function automatic ex_pkg::fu_type_e pick_unit(input logic [1:0] sel);
        case (sel)
            2'd0:    return ex_pkg::FU_ALU;
            2'd2:    return ex_pkg::FU_BRANCH;
            default: return ex_pkg::FU_MULT;
        endcase
    endfunction

    initial begin
        logic [31:0]      r;
        ex_pkg::fu_type_e unit;
        int               drain;
        clock           = 1'b0;
        reset           = 1'b1;
        issue           = '0;
        rng             = SEED;
        ops_sent        = 0;
        seen_issue      = 1'b0;
        issued_alu      = 0;
        issued_mult     = 0;
        issued_br       = 0;
        leftover_errors = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        // quiet window right after reset
        repeat (3) @(posedge clock);
        while (ops_sent < N_OPS) begin
            @(posedge clock);
            r    = next_random();
            unit = pick_unit(r[4:3]);
            if (r[2:0] != 3'd0 && has_credit(unit)) begin
                issue_op(unit);
            end else begin
                issue <= '0;
            end
        end
        @(posedge clock);
        issue <= '0;
        drain = 0;
        while ((exp_alu.size() + exp_mult.size() + exp_br.size()) != 0 && drain < DRAIN_LIMIT) begin
            @(posedge clock);
            drain++;
        end
        repeat (4) @(posedge clock);
        if ((exp_alu.size() + exp_mult.size() + exp_br.size()) != 0) begin
            leftover_errors++;
            $display("results never arrived: %0d ALU, %0d multiply, %0d branch still expected",
                     exp_alu.size(), exp_mult.size(), exp_br.size());
        end
        $display("errors: %0d value, %0d protocol, %0d missing", value_errors,
                 protocol_errors, leftover_errors);
        if (value_errors + protocol_errors + leftover_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // output monitor, sampled mid cycle
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        freed_alu       = 0;
        freed_mult      = 0;
        freed_br        = 0;
    end

    always @(negedge clock) begin
        ex_pkg::unit_done_t want;
        logic               have;
        logic [2:0]         frees;
        logic [2:0]         expect_frees;
        have  = 1'b0;
        want  = '0;
        frees = {free_alu, free_mult, free_branch};
        if (!seen_issue) begin
            if (result.valid !== 1'b0 || frees !== 3'b000) begin
                protocol_errors++;
                $display("output active at %0t before any issue", $time);
            end
        end else if (result.valid) begin
            case (result.unit)
                ex_pkg::FU_ALU: if (exp_alu.size() > 0) begin
                    want = exp_alu.pop_front();
                    have = 1'b1;
                end
                ex_pkg::FU_MULT: if (exp_mult.size() > 0) begin
                    want = exp_mult.pop_front();
                    have = 1'b1;
                end
                ex_pkg::FU_BRANCH: if (exp_br.size() > 0) begin
                    want = exp_br.pop_front();
                    have = 1'b1;
                end
                default: ;
            endcase
            if (!have) begin
                protocol_errors++;
                $display("unexpected output at %0t from unit %0d with nothing outstanding",
                         $time, result.unit);
            end else begin
                check_word(result.unit.name(), result.result, want.result);
                check_flag(result.unit.name(), result.take_branch, want.take_branch);
                check_tag(result.unit.name(), result.tag, want.tag);
            end
            expect_frees = {result.unit == ex_pkg::FU_ALU, result.unit == ex_pkg::FU_MULT,
                            result.unit == ex_pkg::FU_BRANCH};
            if (frees !== expect_frees) begin
                protocol_errors++;
                $display("free pulses %b at %0t do not match the unit of the output", frees,
                         $time);
            end
        end else if (frees !== 3'b000) begin
            protocol_errors++;
            $display("free pulse at %0t without a valid output", $time);
        end
        freed_alu  += int'(free_alu === 1'b1);
        freed_mult += int'(free_mult === 1'b1);
        freed_br   += int'(free_branch === 1'b1);
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("run stopped by the watchdog after %0d of %0d operations", ops_sent, N_OPS);
        $display("tests failed");
        $finish;
    end

endmodule
